/* src.f */
hw/ghtPkg.sv
hw/ghtBank.sv
hw/ghtIndexHash.sv
hw/ghtControl.sv
hw/ghtPredMerge.sv
hw/ghtPredictor.sv
dv/ghtTb.sv

/* run.sh */
#!/usr/bin/env bash
# compile with Verilator, run, then search the log for the fail message
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing -f src.f --top-module ghtTb --Mdir "$BUILD" -o ghtSim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./$BUILD/ghtSim" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Simulation failed" "$LOG"; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi
exit 0

/* dv/ghtTb.sv */
// direction table testbench with clock, reset and stimulus table
// shadow counter model and slot prediction checks
`default_nettype none

module ghtTb;

    typedef struct packed {
        ghtPkg::tableWrite_t w0;
        ghtPkg::tableWrite_t w1;
        logic readEn;
        ghtPkg::pc_t pc;
        ghtPkg::hist_t ghist;
        ghtPkg::slotMask_t mask;
        ghtPkg::slotMask_t taken;
        ghtPkg::counter_t [ghtPkg::NumSlots-1:0] btbCnt;
        logic check;
    } stimEntry_t;

    logic clk;
    logic rst;
    logic readEn;
    ghtPkg::pc_t pc;
    ghtPkg::hist_t ghist;
    ghtPkg::slotMask_t jumpMask;
    ghtPkg::slotMask_t btbTaken;
    ghtPkg::counter_t [ghtPkg::NumSlots-1:0] btbCounter;
    ghtPkg::tableWrite_t write0;
    ghtPkg::tableWrite_t write1;
    ghtPkg::counter_t [ghtPkg::NumSlots-1:0] slotPred;
    logic ready;

    integer seed;
    int cycleCount;
    int cycleLimit;
    stimEntry_t stim[$];

    // shadow of every counter and the pending deferred write
    ghtPkg::counter_t shadow [ghtPkg::NumBanks][ghtPkg::NumRows][256];
    ghtPkg::tableWrite_t savedWr;
    logic savedValid;

    // lookup as the DUT should have registered it
    ghtPkg::pc_t mPc;
    ghtPkg::hist_t mGhist;
    ghtPkg::slotMask_t mMask;
    ghtPkg::slotMask_t mTaken;
    ghtPkg::counter_t [ghtPkg::NumSlots-1:0] mBtb;

    ghtPredictor #(
        .rowCount(ghtPkg::NumRows)
    ) UUT (
        .clk(clk),
        .rst(rst),
        .readEn(readEn),
        .pc(pc),
        .ghist(ghist),
        .jumpMask(jumpMask),
        .btbTaken(btbTaken),
        .btbCounter(btbCounter),
        .write0(write0),
        .write1(write1),
        .slotPred(slotPred),
        .ready(ready)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > cycleLimit) begin
            failRun($sformatf("timeout: run did not finish within %0d cycles", cycleLimit));
        end
    end

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            failRun($sformatf("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    function automatic ghtPkg::counter_t randomCounter();
        logic [31:0] v;

        v = $random(seed);
        // never zero so a landed write is visible
        return ghtPkg::counter_t'(2'd1 + (v[1:0] % 2'd3));
    endfunction

    function automatic ghtPkg::pc_t randomAddr();
        logic [31:0] v;

        v = $random(seed);
        return v[15:0];
    endfunction

    function automatic ghtPkg::tableWrite_t makeWrite(input ghtPkg::pc_t addr,
                                                      input ghtPkg::counter_t cnt);
        ghtPkg::tableWrite_t w;

        w.addr = addr;
        w.counter = cnt;
        w.wen = 1'b1;
        return w;
    endfunction

    function automatic ghtPkg::bankSel_t addrBank(input ghtPkg::pc_t addr);
        return {addr[7:6], addr[0]};
    endfunction

    task automatic addEntry(input ghtPkg::tableWrite_t w0, input ghtPkg::tableWrite_t w1,
                            input logic rd, input ghtPkg::pc_t p, input ghtPkg::hist_t gh,
                            input ghtPkg::slotMask_t mask, input ghtPkg::slotMask_t taken,
                            input logic [7:0] cnt, input logic chk);
        stimEntry_t e;

        e.w0 = w0;
        e.w1 = w1;
        e.readEn = rd;
        e.pc = p;
        e.ghist = gh;
        e.mask = mask;
        e.taken = taken;
        e.btbCnt = cnt;
        e.check = chk;
        stim.push_back(e);
    endtask

    task automatic addLookup(input ghtPkg::pc_t p, input ghtPkg::hist_t gh,
                             input ghtPkg::slotMask_t mask);
        addEntry('0, '0, 1'b1, p, gh, mask, 4'b0000, 8'h00, 1'b1);
    endtask

    task automatic addWrites(input ghtPkg::tableWrite_t w0, input ghtPkg::tableWrite_t w1);
        addEntry(w0, w1, 1'b0, '0, '0, '0, 4'b0000, 8'h00, 1'b0);
    endtask

    task automatic buildTable();
        ghtPkg::pc_t rA;
        ghtPkg::pc_t rB;
        ghtPkg::pc_t rC;
        ghtPkg::pc_t rD;
        logic [31:0] v;

        rA = randomAddr();
        rB = randomAddr();
        rC = randomAddr();
        rD = randomAddr();
        v = $random(seed);

        // cleared table including rows hit by writes during init
        addLookup(16'h1234, 8'h5A, 4'b1111);
        addLookup(16'h3A14, 8'h00, 4'b1111);
        addLookup(16'h5C14, 8'h00, 4'b1111);
        addLookup(randomAddr(), v[7:0], 4'b1111);

        // single write then its location and a neighbor column
        addWrites(makeWrite(rA, randomCounter()), '0);
        addLookup(rA, 8'h00, 4'b1111);
        addLookup(rA ^ 16'h0100, 8'h00, 4'b1111);
        addLookup(rA, 8'h00, 4'b0001);

        // slot 2 column shifted by two under 1111 and unshifted under 0100
        addWrites(makeWrite(16'h98AA, 2'd2), makeWrite(16'h79AA, 2'd3));
        addLookup(16'h4C2A, 8'h35, 4'b1111);
        addLookup(16'h4C2A, 8'h35, 4'b0100);

        // BTB override and masked slots
        addEntry('0, '0, 1'b1, 16'h4C2A, 8'h35, 4'b1111, 4'b0101, 8'b10_01_11_01, 1'b1);
        addEntry('0, '0, 1'b1, 16'h4C2A, 8'h35, 4'b1011, 4'b0100, 8'hFF, 1'b1);

        // different banks land together and same bank defers port 1
        addEntry(makeWrite(rB, randomCounter()), makeWrite(rB ^ 16'h0040, randomCounter()),
                 1'b1, rB, 8'h00, 4'b1111, 4'b0000, 8'h00, 1'b1);
        addEntry(makeWrite(rC, randomCounter()), makeWrite(rC ^ 16'h0100, randomCounter()),
                 1'b1, rC, 8'h00, 4'b1111, 4'b0000, 8'h00, 1'b1);
        addLookup(rC ^ 16'h0100, 8'h00, 4'b1111);
        addLookup(rC, 8'h00, 4'b1111);

        // buffer busy with both ports on the saved bank so port 1 is lost
        addWrites(makeWrite(rD, randomCounter()), makeWrite(rD ^ 16'h0100, randomCounter()));
        addWrites(makeWrite(rD ^ 16'h0200, randomCounter()),
                  makeWrite(rD ^ 16'h0300, randomCounter()));
        addLookup(rD, 8'h00, 4'b1111);
        addLookup(rD ^ 16'h0100, 8'h00, 4'b1111);
        addLookup(rD ^ 16'h0200, 8'h00, 4'b1111);
        addLookup(rD ^ 16'h0300, 8'h00, 4'b1111);
    endtask

    task automatic storeShadow(input ghtPkg::tableWrite_t w);
        shadow[addrBank(w.addr)][w.addr[5:1]][w.addr[15:8]] = w.counter;
    endtask

    // what the next clock edge does to the table and the lookup
    task automatic applyEdge(input stimEntry_t e);
        logic g0;
        logic g1;
        logic c0;
        logic c1;
        ghtPkg::bankSel_t b0;
        ghtPkg::bankSel_t b1;
        ghtPkg::bankSel_t bs;

        b0 = addrBank(e.w0.addr);
        b1 = addrBank(e.w1.addr);
        bs = addrBank(savedWr.addr);
        if (savedValid) begin
            storeShadow(savedWr);
        end
        g0 = e.w0.wen && !(savedValid && b0 == bs);
        c0 = e.w0.wen && !g0;
        g1 = e.w1.wen && !(savedValid && b1 == bs) && !(g0 && b1 == b0);
        c1 = e.w1.wen && !g1 && !c0;
        if (g0) begin
            storeShadow(e.w0);
        end
        if (g1) begin
            storeShadow(e.w1);
        end
        if (c0) begin
            savedWr = e.w0;
        end else if (c1) begin
            savedWr = e.w1;
        end
        savedValid = c0 || c1;
        if (e.readEn) begin
            mPc = e.pc;
            mGhist = e.ghist;
            mMask = e.mask;
            mTaken = e.taken;
            mBtb = e.btbCnt;
        end
    endtask

    function automatic ghtPkg::counter_t expectSlot(input int k);
        int j;
        ghtPkg::hist_t sh;
        ghtPkg::colIdx_t col;
        ghtPkg::bankSel_t bank;
        ghtPkg::rowIdx_t row;

        j = 0;
        for (int i = 0; i < k; i++) begin
            j = j + int'(mMask[i]);
        end
        sh = mGhist << j;
        col = mPc[15:8] ^ sh;
        bank = {mPc[7:6] ^ 2'(k), mPc[0]};
        row = mPc[5:1];
        if (!mMask[k]) begin
            return 2'd0;
        end else if (mTaken[k]) begin
            return mBtb[k];
        end
        return shadow[bank][row][col];
    endfunction

    initial begin
        stimEntry_t e;
        int waited;

        seed = 32'h4135;
        cycleCount = 0;
        cycleLimit = 1000;
        rst = 1'b1;
        readEn = 1'b0;
        pc = '0;
        ghist = '0;
        jumpMask = '0;
        btbTaken = '0;
        btbCounter = '0;
        write0 = '0;
        write1 = '0;
        savedWr = '0;
        savedValid = 1'b0;
        for (int b = 0; b < ghtPkg::NumBanks; b++) begin
            for (int r = 0; r < ghtPkg::NumRows; r++) begin
                for (int c = 0; c < 256; c++) begin
                    shadow[b][r][c] = 2'd0;
                end
            end
        end

        buildTable();
        cycleLimit = 100 + 4 * stim.size();

        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        checkValue("ready", 32'(ready), 32'd0);

        // updates during the init sweep must be ignored
        write0 = makeWrite(16'h3A14, 2'd3);
        write1 = makeWrite(16'h5C14, 2'd2);
        waited = 0;
        while (ready !== 1'b1) begin
            if (waited == 40) begin
                failRun("ready did not rise within 40 cycles of reset release");
            end
            @(negedge clk);
            waited = waited + 1;
        end
        write0 = '0;
        write1 = '0;

        for (int i = 0; i < stim.size(); i++) begin
            e = stim[i];
            write0 = e.w0;
            write1 = e.w1;
            readEn = e.readEn;
            pc = e.pc;
            ghist = e.ghist;
            jumpMask = e.mask;
            btbTaken = e.taken;
            btbCounter = e.btbCnt;
            applyEdge(e);
            @(negedge clk);
            if (e.check) begin
                for (int k = 0; k < ghtPkg::NumSlots; k++) begin
                    checkValue($sformatf("slotPred[%0d]", k), 32'(slotPred[k]),
                               32'(expectSlot(k)));
                end
                checkValue("ready", 32'(ready), 32'd1);
            end
        end

        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

/* hw/ghtPredictor.sv */
// top of the global-history direction table
// lookup registers, hash, eight counter banks, write control and merge
`default_nettype none

module ghtPredictor #(
    parameter int rowCount = ghtPkg::NumRows
) (
    input wire logic clk,
    input wire logic rst,
    input wire logic readEn,
    input wire ghtPkg::pc_t pc,
    input wire ghtPkg::hist_t ghist,
    input wire ghtPkg::slotMask_t jumpMask,
    input wire ghtPkg::slotMask_t btbTaken,
    input wire ghtPkg::counter_t [ghtPkg::NumSlots-1:0] btbCounter,
    input wire ghtPkg::tableWrite_t write0,
    input wire ghtPkg::tableWrite_t write1,
    output wire ghtPkg::counter_t [ghtPkg::NumSlots-1:0] slotPred,
    output wire logic ready
);

    ghtPkg::pc_t pcReg;
    ghtPkg::hist_t ghistReg;
    ghtPkg::slotMask_t jumpMaskReg;
    ghtPkg::slotMask_t btbTakenReg;
    ghtPkg::counter_t [ghtPkg::NumSlots-1:0] btbCounterReg;

    ghtPkg::colIdx_t [ghtPkg::NumBanks-1:0] bankCol;
    ghtPkg::bankSel_t [ghtPkg::NumSlots-1:0] slotBank;
    ghtPkg::counter_t [ghtPkg::NumBanks-1:0] bankCounter;
    ghtPkg::bankWrite_t [ghtPkg::NumBanks-1:0] bankWr;
    logic clear;

    // lookup is held until the next readEn
    always_ff @(posedge clk) begin
        if (rst) begin
            jumpMaskReg <= '0;
            btbTakenReg <= '0;
        end else if (readEn) begin
            jumpMaskReg <= jumpMask;
            btbTakenReg <= btbTaken;
        end
    end

    always_ff @(posedge clk) begin
        if (readEn) begin
            pcReg <= pc;
            ghistReg <= ghist;
            btbCounterReg <= btbCounter;
        end
    end

    ghtIndexHash indexHash (
        .pc(pcReg),
        .ghist(ghistReg),
        .jumpMask(jumpMaskReg),
        .bankCol(bankCol),
        .slotBank(slotBank)
    );

    ghtControl control (
        .clk(clk),
        .rst(rst),
        .write0(write0),
        .write1(write1),
        .bankWr(bankWr),
        .clear(clear),
        .ready(ready)
    );

    // all banks share the row taken from pc[5:1]
    for (genvar b = 0; b < ghtPkg::NumBanks; b++) begin : genBank
        ghtBank #(
            .rowCount(rowCount)
        ) bank (
            .clk(clk),
            .wr(bankWr[b]),
            .clear(clear),
            .rdRow(pcReg[5:1]),
            .rdCol(bankCol[b]),
            .rdCounter(bankCounter[b])
        );
    end

    ghtPredMerge predMerge (
        .bankCounter(bankCounter),
        .slotBank(slotBank),
        .jumpMask(jumpMaskReg),
        .btbTaken(btbTakenReg),
        .btbCounter(btbCounterReg),
        .slotPred(slotPred)
    );

endmodule

`default_nettype wire

/* hw/ghtPredMerge.sv */
// per-slot choice between the table counter and the BTB counter
`default_nettype none

module ghtPredMerge (
    input wire ghtPkg::counter_t [ghtPkg::NumBanks-1:0] bankCounter,
    input wire ghtPkg::bankSel_t [ghtPkg::NumSlots-1:0] slotBank,
    input wire ghtPkg::slotMask_t jumpMask,
    input wire ghtPkg::slotMask_t btbTaken,
    input wire ghtPkg::counter_t [ghtPkg::NumSlots-1:0] btbCounter,
    output ghtPkg::counter_t [ghtPkg::NumSlots-1:0] slotPred
);

    ghtPkg::counter_t [ghtPkg::NumSlots-1:0] tableCounter;

    // gather each slot's counter from its bank
    always_comb begin
        for (int k = 0; k < ghtPkg::NumSlots; k++) begin
            tableCounter[k] = bankCounter[slotBank[k]];
        end
    end

    always_comb begin
        for (int k = 0; k < ghtPkg::NumSlots; k++) begin
            if (!jumpMask[k]) begin
                // not a conditional jump
                slotPred[k] = '0;
            end else if (btbTaken[k]) begin
                slotPred[k] = btbCounter[k];
            end else begin
                slotPred[k] = tableCounter[k];
            end
        end
    end

endmodule

`default_nettype wire

/* hw/ghtControl.sv */
// init sweep over all rows, arbitration of the two update ports
// and the one-entry save buffer for same-bank conflicts
`default_nettype none

module ghtControl (
    input wire logic clk,
    input wire logic rst,
    input wire ghtPkg::tableWrite_t write0,
    input wire ghtPkg::tableWrite_t write1,
    output ghtPkg::bankWrite_t [ghtPkg::NumBanks-1:0] bankWr,
    output logic clear,
    output logic ready
);

    logic initActive;
    ghtPkg::rowIdx_t initRow;

    ghtPkg::tableWrite_t saved;
    logic saveValid;

    ghtPkg::bankSel_t bank0;
    ghtPkg::bankSel_t bank1;
    ghtPkg::bankSel_t bankS;

    logic grant0;
    logic grant1;
    logic capture0;
    logic capture1;

    function automatic ghtPkg::bankSel_t bankOf(input ghtPkg::pc_t addr);
        return {addr[7:6], addr[0]};
    endfunction

    function automatic ghtPkg::bankWrite_t toBankWrite(input ghtPkg::tableWrite_t w);
        ghtPkg::bankWrite_t r;

        r.row = w.addr[5:1];
        r.col = w.addr[15:8];
        r.counter = w.counter;
        r.wen = 1'b1;
        return r;
    endfunction

    assign bank0 = bankOf(write0.addr);
    assign bank1 = bankOf(write1.addr);
    assign bankS = bankOf(saved.addr);

    // saved entry first, then port 0, then port 1
    always_comb begin
        grant0 = ~initActive & write0.wen & ~(saveValid & (bank0 == bankS));
        capture0 = ~initActive & write0.wen & ~grant0;
        grant1 = ~initActive & write1.wen
            & ~(saveValid & (bank1 == bankS))
            & ~(grant0 & (bank1 == bank0));
        // only one slot in the buffer, a second loser is dropped
        capture1 = ~initActive & write1.wen & ~grant1 & ~capture0;
    end

    always_comb begin
        for (int b = 0; b < ghtPkg::NumBanks; b++) begin
            bankWr[b] = '0;
            if (initActive) begin
                bankWr[b].row = initRow;
                bankWr[b].wen = 1'b1;
            end else if (saveValid && bankS == ghtPkg::bankSel_t'(b)) begin
                bankWr[b] = toBankWrite(saved);
            end else if (grant0 && bank0 == ghtPkg::bankSel_t'(b)) begin
                bankWr[b] = toBankWrite(write0);
            end else if (grant1 && bank1 == ghtPkg::bankSel_t'(b)) begin
                bankWr[b] = toBankWrite(write1);
            end
        end
    end

    assign clear = initActive;
    assign ready = ~initActive;

    always_ff @(posedge clk) begin
        if (rst) begin
            initActive <= 1'b1;
            initRow <= '0;
            saveValid <= 1'b0;
        end else begin
            if (initActive) begin
                initRow <= initRow + 1'b1;
                if (initRow == ghtPkg::rowIdx_t'(ghtPkg::NumRows - 1)) begin
                    initActive <= 1'b0;
                end
            end
            // a captured write is replayed in the next cycle
            saveValid <= capture0 | capture1;
        end
    end

    always_ff @(posedge clk) begin
        if (capture0) begin
            saved <= write0;
        end else if (capture1) begin
            saved <= write1;
        end
    end

endmodule

`default_nettype wire

/* hw/ghtIndexHash.sv */
// per-slot history shift and column hash
// slot to bank mapping and per-bank read column steering
`default_nettype none

module ghtIndexHash (
    input wire ghtPkg::pc_t pc,
    input wire ghtPkg::hist_t ghist,
    input wire ghtPkg::slotMask_t jumpMask,
    output ghtPkg::colIdx_t [ghtPkg::NumBanks-1:0] bankCol,
    output ghtPkg::bankSel_t [ghtPkg::NumSlots-1:0] slotBank
);

    ghtPkg::colIdx_t [ghtPkg::NumSlots-1:0] slotCol;

    // column and bank of every slot
    always_comb begin
        logic [1:0] earlier;
        ghtPkg::hist_t shifted;

        earlier = '0;
        shifted = '0;
        for (int k = 0; k < ghtPkg::NumSlots; k++) begin
            // conditional jumps ahead of this slot in the bundle
            earlier = '0;
            for (int i = 0; i < k; i++) begin
                earlier = earlier + 2'(jumpMask[i]);
            end
            shifted = ghist << earlier;
            slotCol[k] = pc[15:8] ^ shifted;
            slotBank[k] = {pc[7:6] ^ 2'(k), pc[0]};
        end
    end

    // slots always hit distinct banks, idle banks read column 0
    always_comb begin
        bankCol = '0;
        for (int k = 0; k < ghtPkg::NumSlots; k++) begin
            bankCol[slotBank[k]] = slotCol[k];
        end
    end

endmodule

`default_nettype wire

/* hw/ghtBank.sv */
// one bank of 2-bit counters, rows of 256 columns
// column write, whole-row clear and asynchronous column read
`default_nettype none

module ghtBank #(
    parameter int rowCount = 32
) (
    input wire logic clk,
    input wire ghtPkg::bankWrite_t wr,
    input wire logic clear,
    input wire ghtPkg::rowIdx_t rdRow,
    input wire ghtPkg::colIdx_t rdCol,
    output wire ghtPkg::counter_t rdCounter
);

    localparam int colCount = 1 << $bits(ghtPkg::colIdx_t);

    typedef ghtPkg::counter_t [colCount-1:0] row_t;

    row_t rows [rowCount];
    row_t rdRowData;

    // read sees the array directly, so a write shows after its edge
    assign rdRowData = rows[rdRow];
    assign rdCounter = rdRowData[rdCol];

    // init sweep zeroes a full row, updates touch one column
    always_ff @(posedge clk) begin
        if (clear) begin
            rows[wr.row] <= '0;
        end else if (wr.wen) begin
            rows[wr.row][wr.col] <= wr.counter;
        end
    end

endmodule

`default_nettype wire

/* hw/ghtPkg.sv */
// shared widths, bundle constants and write structs
// for the global-history direction table
`default_nettype none

package ghtPkg;

    localparam int NumBanks = 8;
    localparam int NumSlots = 4;
    localparam int NumRows = 32;

    typedef logic [15:0] pc_t;
    typedef logic [7:0] hist_t;
    typedef logic [1:0] counter_t;

    // {addr[7:6], addr[0]}
    typedef logic [2:0] bankSel_t;
    // addr[5:1]
    typedef logic [4:0] rowIdx_t;
    // addr[15:8] after the history xor
    typedef logic [7:0] colIdx_t;

    typedef logic [3:0] slotMask_t;

    // update port, 19 bits
    typedef struct packed {
        pc_t addr;
        counter_t counter;
        logic wen;
    } tableWrite_t;

    // write as seen by one bank, 16 bits
    typedef struct packed {
        rowIdx_t row;
        colIdx_t col;
        counter_t counter;
        logic wen;
    } bankWrite_t;

endpackage

`default_nettype wire
